/* common/gameGeometryPkg.sv */
// Screen geometry shared by the movers and the overlap test
// Coordinates are sprite centers in a 640x480 frame and never wrap
// Every sprite is a square of the same size
package gameGeometryPkg;

    // Unsigned screen coordinate of a sprite center
    typedef logic [9:0] coordT;

    // Per-frame displacement in two's complement
    typedef logic [9:0] motionT;

    // Last visible column
    localparam coordT screenXMax = 10'd639;

    // Last visible row
    localparam coordT screenYMax = 10'd479;

    // Half the side length of every square
    localparam coordT spriteHalf = 10'd8;

    // Extra gap the player keeps from the border
    localparam coordT edgeMargin = 10'd5;

    // Player column that completes a level
    localparam coordT finishX = 10'd600;

endpackage

/* common/gameControlPkg.sv */
// Keyboard codes and game progress types
// Keycodes are USB HID usage codes for W, S, A and D
package gameControlPkg;

    // Raw keycode of the held key, zero when idle
    typedef logic [7:0] keycodeT;

    // Steering keys
    localparam keycodeT keyUp    = 8'h1A;
    localparam keycodeT keyDown  = 8'h16;
    localparam keycodeT keyLeft  = 8'h04;
    localparam keycodeT keyRight = 8'h07;

    // Level index, also added to the obstacle step
    typedef logic [1:0] levelT;

    // Remaining lives
    typedef logic [1:0] livesT;

    // Lives at power up
    localparam livesT startLives = 2'd3;

    // Level controller states
    typedef enum logic
    {
        playing,
        gameOver
    } levelStateT;

endpackage

/* player/playerMotion.sv */
`timescale 1ns/1ps
// Player moves only while a key is held
// Keycodes other than the four steering keys keep the last motion
// Edge bounce looks at the current position only
module playerMotion #(
    parameter int playerStep = 3
)
(
    input  logic                   frame_clk,
    input  logic                   rstN,
    input  gameControlPkg::keycodeT keycode,
    input  logic                   restartLevel,
    input  logic                   nextLevel,
    input  logic                   freeze,
    output gameGeometryPkg::coordT posX,
    output gameGeometryPkg::coordT posY
);

    // Step in both directions
    localparam gameGeometryPkg::motionT stepPos = gameGeometryPkg::motionT'(playerStep);
    localparam gameGeometryPkg::motionT stepNeg = gameGeometryPkg::motionT'(-playerStep);

    // Distance from a border where the bounce starts
    localparam gameGeometryPkg::coordT nearEdge =
        gameGeometryPkg::spriteHalf + gameGeometryPkg::edgeMargin;

    // Reload positions
    localparam gameGeometryPkg::coordT restartX = 10'd20;
    localparam gameGeometryPkg::coordT finishRestartX = 10'd30;
    localparam gameGeometryPkg::coordT startY = 10'd240;

    gameGeometryPkg::motionT motionX;
    gameGeometryPkg::motionT motionY;
    gameGeometryPkg::motionT motionXNext;
    gameGeometryPkg::motionT motionYNext;

    always_comb
    begin
        // Keep last motion unless a steering key says otherwise
        motionXNext = motionX;
        motionYNext = motionY;

        case (keycode)
            gameControlPkg::keyUp:
            begin
                motionXNext = '0;
                motionYNext = stepNeg;
            end
            gameControlPkg::keyDown:
            begin
                motionXNext = '0;
                motionYNext = stepPos;
            end
            gameControlPkg::keyLeft:
            begin
                motionXNext = stepNeg;
                motionYNext = '0;
            end
            gameControlPkg::keyRight:
            begin
                motionXNext = stepPos;
                motionYNext = '0;
            end
            default:
            begin
                motionXNext = motionX;
            end
        endcase

        // Bottom and top borders push the player back in
        if ((posY + nearEdge) >= gameGeometryPkg::screenYMax)
        begin
            motionYNext = stepNeg;
        end
        else if (posY <= nearEdge)
        begin
            motionYNext = stepPos;
        end

        // Same for right and left
        if ((posX + nearEdge) >= gameGeometryPkg::screenXMax)
        begin
            motionXNext = stepNeg;
        end
        else if (posX <= nearEdge)
        begin
            motionXNext = stepPos;
        end
    end

    always_ff @(posedge frame_clk or negedge rstN)
    begin
        if (!rstN)
        begin
            posX    <= restartX;
            posY    <= startY;
            motionX <= '0;
            motionY <= '0;
        end
        else if (!freeze)
        begin
            // Hit restart wins over level finish
            if (restartLevel)
            begin
                posX    <= restartX;
                posY    <= startY;
                motionX <= '0;
                motionY <= '0;
            end
            else if (nextLevel)
            begin
                posX    <= finishRestartX;
                posY    <= startY;
                motionX <= '0;
                motionY <= '0;
            end
            else if (keycode != '0)
            begin
                posX    <= posX + motionXNext;
                posY    <= posY + motionYNext;
                motionX <= motionXNext;
                motionY <= motionYNext;
            end
        end
    end

    // Level controller must never request both reloads in one frame
    assert property (@(posedge frame_clk) disable iff (!rstN)
        !(restartLevel && nextLevel));

endmodule

/* obstacle/obstacleMotion.sv */
`timescale 1ns/1ps
// Diagonal bouncing square, step is baseStep plus the current level
// baseStep plus maxLevel must stay below spriteHalf to keep it on screen
module obstacleMotion #(
    parameter int startX   = 320,
    parameter int startY   = 240,
    parameter int baseStep = 4
)
(
    input  logic                   frame_clk,
    input  logic                   rstN,
    input  gameControlPkg::levelT  level,
    input  logic                   restartLevel,
    input  logic                   freeze,
    output gameGeometryPkg::coordT posX,
    output gameGeometryPkg::coordT posY
);

    localparam gameGeometryPkg::coordT homeX = gameGeometryPkg::coordT'(startX);
    localparam gameGeometryPkg::coordT homeY = gameGeometryPkg::coordT'(startY);

    // Magnitude of the step this frame
    gameGeometryPkg::motionT stepSize;

    // Direction flags, set means moving toward zero
    logic dirXNeg;
    logic dirYNeg;
    logic dirXNegNext;
    logic dirYNegNext;

    gameGeometryPkg::motionT moveX;
    gameGeometryPkg::motionT moveY;

    // Faster at higher levels
    assign stepSize = gameGeometryPkg::motionT'(baseStep) + gameGeometryPkg::motionT'(level);

    always_comb
    begin
        dirXNegNext = dirXNeg;
        dirYNegNext = dirYNeg;

        // Right border reached
        if ((posX + gameGeometryPkg::spriteHalf) >= gameGeometryPkg::screenXMax)
        begin
            dirXNegNext = 1'b1;
        end
        // Left border reached
        else if (posX <= gameGeometryPkg::spriteHalf)
        begin
            dirXNegNext = 1'b0;
        end

        // Bottom border
        if ((posY + gameGeometryPkg::spriteHalf) >= gameGeometryPkg::screenYMax)
        begin
            dirYNegNext = 1'b1;
        end
        // Top border
        else if (posY <= gameGeometryPkg::spriteHalf)
        begin
            dirYNegNext = 1'b0;
        end

        // Signed displacement from direction and step
        moveX = dirXNegNext ? -stepSize : stepSize;
        moveY = dirYNegNext ? -stepSize : stepSize;
    end

    always_ff @(posedge frame_clk or negedge rstN)
    begin
        if (!rstN)
        begin
            posX    <= homeX;
            posY    <= homeY;
            dirXNeg <= 1'b0;
            dirYNeg <= 1'b0;
        end
        else if (!freeze)
        begin
            if (restartLevel)
            begin
                // Back home, heading down and right
                posX    <= homeX;
                posY    <= homeY;
                dirXNeg <= 1'b0;
                dirYNeg <= 1'b0;
            end
            else
            begin
                posX    <= posX + moveX;
                posY    <= posY + moveY;
                dirXNeg <= dirXNegNext;
                dirYNeg <= dirYNegNext;
            end
        end
    end

    // Bounce plus level speed must keep the square on screen
    assert property (@(posedge frame_clk) disable iff (!rstN)
        (posX <= gameGeometryPkg::screenXMax) && (posY <= gameGeometryPkg::screenYMax));

endmodule

/* logic/collisionDetect.sv */
`timescale 1ns/1ps
// Box overlap of the player against two obstacles, one frame late
// A hit frame is always followed by a quiet frame while movers reload
module collisionDetect
(
    input  logic                   frame_clk,
    input  logic                   rstN,
    input  gameGeometryPkg::coordT playerX,
    input  gameGeometryPkg::coordT playerY,
    input  gameGeometryPkg::coordT obsX0,
    input  gameGeometryPkg::coordT obsY0,
    input  gameGeometryPkg::coordT obsX1,
    input  gameGeometryPkg::coordT obsY1,
    output logic                   hit
);

    // Centers closer than a full side on both axes means overlap
    localparam gameGeometryPkg::coordT hitSpan =
        gameGeometryPkg::spriteHalf + gameGeometryPkg::spriteHalf;

    function automatic logic boxOverlap(
        input gameGeometryPkg::coordT ax,
        input gameGeometryPkg::coordT ay,
        input gameGeometryPkg::coordT bx,
        input gameGeometryPkg::coordT by
    );
        gameGeometryPkg::coordT dx;
        gameGeometryPkg::coordT dy;
        // Absolute differences without going signed
        dx = (ax > bx) ? (ax - bx) : (bx - ax);
        dy = (ay > by) ? (ay - by) : (by - ay);
        return (dx < hitSpan) && (dy < hitSpan);
    endfunction

    logic overlap0;
    logic overlap1;

    assign overlap0 = boxOverlap(playerX, playerY, obsX0, obsY0);
    assign overlap1 = boxOverlap(playerX, playerY, obsX1, obsY1);

    always_ff @(posedge frame_clk or negedge rstN)
    begin
        if (!rstN)
        begin
            hit <= 1'b0;
        end
        else
        begin
            // Suppress the stale overlap seen before the reload lands
            hit <= (overlap0 || overlap1) && !hit;
        end
    end

endmodule

/* logic/levelControl.sv */
`timescale 1ns/1ps
// Lives and level bookkeeping, restart and finish pulses are combinational
// Game over is left only through reset
module levelControl #(
    parameter int maxLevel = 3
)
(
    input  logic                   frame_clk,
    input  logic                   rstN,
    input  logic                   hit,
    input  gameGeometryPkg::coordT playerX,
    output logic                   restartLevel,
    output logic                   nextLevel,
    output gameControlPkg::levelT  level,
    output gameControlPkg::livesT  lives,
    output logic                   gameOver
);

    localparam gameControlPkg::levelT levelCap = gameControlPkg::levelT'(maxLevel);

    gameControlPkg::levelStateT state;

    logic playing;
    logic lastLife;

    assign playing = (state == gameControlPkg::playing);

    // Hit with spare lives restarts the level
    assign restartLevel = playing && hit && (lives > 2'd1);

    // Hit on the final life ends the game
    assign lastLife = playing && hit && (lives == 2'd1);

    // Finish column reached, a hit in the same frame wins
    assign nextLevel = playing && !hit && (playerX >= gameGeometryPkg::finishX);

    // Also used as freeze by the movers
    assign gameOver = (state == gameControlPkg::gameOver);

    always_ff @(posedge frame_clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= gameControlPkg::playing;
            lives <= gameControlPkg::startLives;
            level <= '0;
        end
        else
        begin
            case (state)
                gameControlPkg::playing:
                begin
                    if (lastLife)
                    begin
                        state <= gameControlPkg::gameOver;
                        lives <= '0;
                    end
                    else if (restartLevel)
                    begin
                        lives <= lives - 2'd1;
                    end

                    // Saturate at the top level
                    if (nextLevel && (level < levelCap))
                    begin
                        level <= level + 2'd1;
                    end
                end
                default:
                begin
                    // Hold everything until reset
                    state <= gameControlPkg::gameOver;
                end
            endcase
        end
    end

    // Running out of lives must always move to game over
    assert property (@(posedge frame_clk) disable iff (!rstN)
        (state == gameControlPkg::playing) |-> (lives != '0));

endmodule

/* logic/dodgeGameTop.sv */
`timescale 1ns/1ps
// Frame-stepped dodge game core, one clock per video frame
// Outputs sprite centers and status only, drawing is done elsewhere
module dodgeGameTop #(
    parameter int playerStep = 3,
    parameter int maxLevel   = 3,
    parameter int obs0StartX = 320,
    parameter int obs0StartY = 100,
    parameter int obs0Step   = 4,
    parameter int obs1StartX = 200,
    parameter int obs1StartY = 380,
    parameter int obs1Step   = 2
)
(
    input  logic                    frame_clk,
    input  logic                    rstN,
    input  gameControlPkg::keycodeT keycode,
    output gameGeometryPkg::coordT  playerX,
    output gameGeometryPkg::coordT  playerY,
    output gameGeometryPkg::coordT  obsX0,
    output gameGeometryPkg::coordT  obsY0,
    output gameGeometryPkg::coordT  obsX1,
    output gameGeometryPkg::coordT  obsY1,
    output gameControlPkg::levelT   level,
    output gameControlPkg::livesT   lives,
    output logic                    gameOver
);

    logic hit;
    logic restartLevel;
    logic nextLevel;

    // Key-steered player
    playerMotion #(
        .playerStep(playerStep)
    ) iPlayer (
        .frame_clk   (frame_clk),
        .rstN        (rstN),
        .keycode     (keycode),
        .restartLevel(restartLevel),
        .nextLevel   (nextLevel),
        .freeze      (gameOver),
        .posX        (playerX),
        .posY        (playerY)
    );

    // Fast obstacle in the upper half
    obstacleMotion #(
        .startX  (obs0StartX),
        .startY  (obs0StartY),
        .baseStep(obs0Step)
    ) iObstacle0 (
        .frame_clk   (frame_clk),
        .rstN        (rstN),
        .level       (level),
        .restartLevel(restartLevel),
        .freeze      (gameOver),
        .posX        (obsX0),
        .posY        (obsY0)
    );

    // Slow obstacle in the lower half
    obstacleMotion #(
        .startX  (obs1StartX),
        .startY  (obs1StartY),
        .baseStep(obs1Step)
    ) iObstacle1 (
        .frame_clk   (frame_clk),
        .rstN        (rstN),
        .level       (level),
        .restartLevel(restartLevel),
        .freeze      (gameOver),
        .posX        (obsX1),
        .posY        (obsY1)
    );

    collisionDetect iCollision (
        .frame_clk(frame_clk),
        .rstN     (rstN),
        .playerX  (playerX),
        .playerY  (playerY),
        .obsX0    (obsX0),
        .obsY0    (obsY0),
        .obsX1    (obsX1),
        .obsY1    (obsY1),
        .hit      (hit)
    );

    levelControl #(
        .maxLevel(maxLevel)
    ) iLevelControl (
        .frame_clk   (frame_clk),
        .rstN        (rstN),
        .hit         (hit),
        .playerX     (playerX),
        .restartLevel(restartLevel),
        .nextLevel   (nextLevel),
        .level       (level),
        .lives       (lives),
        .gameOver    (gameOver)
    );

endmodule

/* verification/dodgeGameTb.sv */
`timescale 1ns/1ps
// Stimulus file is opened relative to the project root
// Each data line holds a key for some frames and the outputs expected after them
module dodgeGameTb;

    // Expected columns per data line
    localparam int expCols = 7;

    logic                    frame_clk;
    logic                    rstN;
    gameControlPkg::keycodeT keycode;

    gameGeometryPkg::coordT playerX;
    gameGeometryPkg::coordT playerY;
    gameGeometryPkg::coordT obsX0;
    gameGeometryPkg::coordT obsY0;
    gameGeometryPkg::coordT obsX1;
    gameGeometryPkg::coordT obsY1;
    gameControlPkg::levelT  level;
    gameControlPkg::livesT  lives;
    logic                   gameOver;

    // One entry per data line, expected values flattened by line
    int frameQ[$];
    int keyQ[$];
    int checkQ[$];
    int expQ[$];

    int  errorCount;
    int  checkCount;
    int  totalFrames;
    bit  stimulusReady;

    dodgeGameTop i_dodgeGameTop (
        .frame_clk(frame_clk),
        .rstN     (rstN),
        .keycode  (keycode),
        .playerX  (playerX),
        .playerY  (playerY),
        .obsX0    (obsX0),
        .obsY0    (obsY0),
        .obsX1    (obsX1),
        .obsY1    (obsY1),
        .level    (level),
        .lives    (lives),
        .gameOver (gameOver)
    );

    // 20 ns frame period
    always
    begin
        #10 frame_clk = ~frame_clk;
    end

    task automatic compareValue(input string name, input int got, input int expected);
        checkCount++;
        if (got != expected)
        begin
            errorCount++;
            $display("** Error: %s got 0x%0h, expected 0x%0h at %0t", name, got, expected,
                $time);
        end
    endtask

    // Outputs after one stimulus line against its expected columns
    task automatic checkLine(input int idx);
        int base;
        int prevLives;
        base = idx * expCols;
        prevLives = (idx == 0) ? 3 : expQ[base - expCols + 4];
        compareValue("playerX", int'(playerX), expQ[base + 0]);
        compareValue("playerY", int'(playerY), expQ[base + 1]);
        compareValue("obsX0", int'(obsX0), expQ[base + 2]);
        compareValue("obsY0", int'(obsY0), expQ[base + 3]);
        compareValue("lives", int'(lives), expQ[base + 4]);
        compareValue("level", int'(level), expQ[base + 5]);
        compareValue("gameOver", int'(gameOver), expQ[base + 6]);

        // A life lost while still playing puts every mover back home
        if ((expQ[base + 4] < prevLives) && (expQ[base + 6] == 0))
        begin
            compareValue("obsX1", int'(obsX1), 200);
            compareValue("obsY1", int'(obsY1), 380);
        end
    endtask

    // Power-up values straight from the game rules
    task automatic checkResetState();
        compareValue("playerX", int'(playerX), 20);
        compareValue("playerY", int'(playerY), 240);
        compareValue("obsX0", int'(obsX0), 320);
        compareValue("obsY0", int'(obsY0), 100);
        compareValue("obsX1", int'(obsX1), 200);
        compareValue("obsY1", int'(obsY1), 380);
        compareValue("lives", int'(lives), 3);
        compareValue("level", int'(level), 0);
        compareValue("gameOver", int'(gameOver), 0);
    endtask

    // Comment lines and blank lines are skipped
    task automatic loadStimulus(output bit ok);
        int    fd;
        int    got;
        int    col[10];
        string lineText;
        ok = 1'b0;
        fd = $fopen("verification/gameStimulus.txt", "r");
        if (fd == 0)
        begin
            return;
        end
        while (!$feof(fd))
        begin
            if ($fgets(lineText, fd) == 0)
            begin
                break;
            end
            if ((lineText.len() == 0) || (lineText.substr(0, 0) == "#"))
            begin
                continue;
            end
            got = $sscanf(lineText, "%d %h %d %d %d %d %d %d %d %d", col[0], col[1],
                col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
            if (got == 10)
            begin
                frameQ.push_back(col[0]);
                keyQ.push_back(col[1]);
                checkQ.push_back(col[2]);
                for (int c = 0; c < expCols; c++)
                begin
                    expQ.push_back(col[c + 3]);
                end
                totalFrames += col[0];
            end
        end
        $fclose(fd);
        ok = (frameQ.size() > 0);
    endtask

    // Run limit follows the frame count in the file
    initial
    begin
        wait (stimulusReady);
        #((longint'(totalFrames) + 100) * 20);
        $display("Timeout: the frames in the stimulus file did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        bit loaded;
        frame_clk  = 1'b0;
        rstN       = 1'b0;
        keycode    = '0;
        errorCount = 0;
        checkCount = 0;
        totalFrames = 0;

        loadStimulus(loaded);
        if (!loaded)
        begin
            $display("Could not read any stimulus lines from verification/gameStimulus.txt");
            $display("=== FAIL ===");
            $finish;
        end
        else
        begin
            stimulusReady = 1'b1;

            // Eight frames in reset, state checked halfway
            repeat (4) @(posedge frame_clk);
            @(negedge frame_clk);
            checkResetState();
            repeat (4) @(posedge frame_clk);
            rstN <= 1'b1;

            fork
                // Key changes land on rising edges
                begin
                    for (int i = 0; i < frameQ.size(); i++)
                    begin
                        keycode <= gameControlPkg::keycodeT'(keyQ[i]);
                        repeat (frameQ[i]) @(posedge frame_clk);
                    end
                end
                // Outputs sampled mid-frame after the line's last edge
                begin
                    for (int i = 0; i < frameQ.size(); i++)
                    begin
                        repeat (frameQ[i]) @(posedge frame_clk);
                        @(negedge frame_clk);
                        if (checkQ[i] != 0)
                        begin
                            checkLine(i);
                        end
                    end
                end
            join

            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            if (errorCount == 0)
            begin
                $display("=== PASS ===");
            end
            else
            begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

/* all.f */
common/gameGeometryPkg.sv
common/gameControlPkg.sv
player/playerMotion.sv
obstacle/obstacleMotion.sv
logic/collisionDetect.sv
logic/levelControl.sv
logic/dodgeGameTop.sv
verification/dodgeGameTb.sv

/* Makefile */
# Verilator build and run for the dodge game testbench

VERILATOR  ?= verilator
TOP        := dodgeGameTb
FILELIST   := all.f
OBJDIR     := obj_dir
FLAGS      := --binary --timing --assert -j 0 --Mdir $(OBJDIR)
LINT_FLAGS := --lint-only --timing -Wall
PASS_TEXT  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* verification/gameStimulus.txt */
# frames keycode(hex) check playerX playerY obsX0 obsY0 lives level gameOver
# keycode is held for the given frames, expected values hold after the last one
5 00 1 20 240 340 120 3 0 0
4 07 1 32 240 356 136 3 0 0
3 00 1 32 240 368 148 3 0 0
3 1A 1 32 231 380 160 3 0 0
2 16 1 32 237 388 168 3 0 0
2 04 1 26 237 396 176 3 0 0
# Long climb into the top border, obstacle 0 bounces off right and bottom
61 1A 1 26 54 624 420 3 0 0
19 1A 1 26 15 548 448 3 0 0
# Park in the path of obstacle 0 and wait for the first hit
27 07 1 107 15 440 340 3 0 0
80 00 1 107 15 120 20 3 0 0
1 00 1 107 15 116 16 3 0 0
1 00 1 20 240 320 100 2 0 0
# Run to the finish column
10 00 1 20 240 360 140 2 0 0
195 07 1 30 240 124 24 2 1 0
5 00 1 30 240 99 9 2 1 0
# Second hit at level 1
37 07 1 141 240 94 194 2 1 0
7 00 1 141 240 129 229 2 1 0
1 00 1 141 240 134 234 2 1 0
1 00 1 20 240 320 100 1 1 0
# Last hit, then everything holds
107 07 1 341 240 415 315 1 1 0
12 00 1 341 240 355 255 1 1 0
2 00 1 341 240 345 245 0 1 1
10 07 1 341 240 345 245 0 1 1
